/* Makefile */
# Verilator build and run of the level-two cache network testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log for failure"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cache_net_tb \
		-f src.f -o Vcache_net_tb
	./obj_dir/Vcache_net_tb | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "test failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || (echo "test failed, no result line"; exit 1)
	@echo "test passed"

clean:
	rm -rf obj_dir $(LOG)

/* hdl/cache_net_top.sv */
//======================================================================
// shared level-two data path: request crossbar, banks, refill network
//======================================================================

`timescale 1ns/1ps

module cache_net_top #(
  parameter int p_num_cores = 4,
  parameter int p_num_lines = 16
) (
  input  logic                       clk,
  input  logic                       reset,

  input  mcore_pkg::req_msg_t        core_req_msg  [p_num_cores],
  input  logic [p_num_cores-1:0]     core_req_val,
  output logic [p_num_cores-1:0]     core_req_rdy,

  output mcore_pkg::resp_msg_t       core_resp_msg [p_num_cores],
  output logic [p_num_cores-1:0]     core_resp_val,
  input  logic [p_num_cores-1:0]     core_resp_rdy,

  output mcore_pkg::req_msg_t        mem_req_msg,
  output logic                       mem_req_val,
  input  logic                       mem_req_rdy,

  input  mcore_pkg::resp_msg_t       mem_resp_msg,
  input  logic                       mem_resp_val,
  output logic                       mem_resp_rdy
);

  net_req_if  #(.p_num_cores(p_num_cores)) bank_req_if  [p_num_cores] ();
  net_resp_if #(.p_num_cores(p_num_cores)) bank_resp_if [p_num_cores] ();
  refill_if                                bank_refill_if [p_num_cores] ();

  mem_net #(.p_num_cores(p_num_cores)) mem_net_inst (
    .clk           (clk),
    .reset         (reset),
    .core_req_msg  (core_req_msg),
    .core_req_val  (core_req_val),
    .core_req_rdy  (core_req_rdy),
    .core_resp_msg (core_resp_msg),
    .core_resp_val (core_resp_val),
    .core_resp_rdy (core_resp_rdy),
    .bank_req      (bank_req_if),
    .bank_resp     (bank_resp_if)
  );

  // one bank per core, word interleaved
  for (genvar g = 0; g < p_num_cores; g++) begin : g_bank
    l2_bank #(.p_num_cores(p_num_cores), .p_num_lines(p_num_lines)) l2_bank_inst (
      .clk    (clk),
      .reset  (reset),
      .req    (bank_req_if[g]),
      .resp   (bank_resp_if[g]),
      .refill (bank_refill_if[g])
    );
  end

  refill_net #(.p_num_cores(p_num_cores)) refill_net_inst (
    .clk          (clk),
    .reset        (reset),
    .bank         (bank_refill_if),
    .mem_req_msg  (mem_req_msg),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_resp_msg (mem_resp_msg),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy)
  );

endmodule

/* hdl/l2_bank.sv */
//======================================================================
// blocking direct-mapped level-two bank, write-through and no
// allocation on a write miss
//======================================================================

`timescale 1ns/1ps

module l2_bank #(
  parameter int p_num_cores = 4,
  parameter int p_num_lines = 16
) (
  input  logic         clk,
  input  logic         reset,
  net_req_if.receiver  req,
  net_resp_if.sender   resp,
  refill_if.requester  refill
);
  import mcore_pkg::*;

  localparam int c_bank_nbits = (p_num_cores > 1) ? $clog2(p_num_cores) : 1;
  localparam int c_idx_nbits  = (p_num_lines > 1) ? $clog2(p_num_lines) : 1;
  localparam int c_idx_lsb    = bank_sel_lsb + c_bank_nbits;
  localparam int c_tag_lsb    = c_idx_lsb + c_idx_nbits;
  localparam int c_tag_nbits  = addr_nbits - c_tag_lsb;

  typedef logic [c_idx_nbits-1:0] line_idx_t;
  typedef logic [c_tag_nbits-1:0] tag_t;

  //====================================================================
  // line storage
  //====================================================================

  data_t                  line_data [p_num_lines];
  tag_t                   line_tag  [p_num_lines];
  logic [p_num_lines-1:0] line_valid;

  //====================================================================
  // request decode and held state
  //====================================================================

  bank_state_t             state_q;
  req_msg_t                req_q;
  logic [c_bank_nbits-1:0] src_q;
  data_t                   resp_data_q;

  addr_t     in_addr;
  line_idx_t in_idx;
  tag_t      in_tag;
  logic      in_wr;
  logic      in_hit;
  addr_t     held_addr;
  line_idx_t held_idx;
  logic      held_wr;
  logic      req_fire;

  assign in_addr   = req.msg[req_addr_lsb +: addr_nbits];
  assign in_idx    = in_addr[c_idx_lsb +: c_idx_nbits];
  assign in_tag    = in_addr[c_tag_lsb +: c_tag_nbits];
  assign in_wr     = req.msg[req_type_lsb];
  assign in_hit    = line_valid[in_idx] && (line_tag[in_idx] == in_tag);

  assign held_addr = req_q[req_addr_lsb +: addr_nbits];
  assign held_idx  = held_addr[c_idx_lsb +: c_idx_nbits];
  assign held_wr   = req_q[req_type_lsb];

  assign req_fire  = req.val && req.rdy;

  // one request at a time per bank
  assign req.rdy = (state_q == s_idle);

  assign refill.req_msg  = req_q;
  assign refill.req_val  = (state_q == s_mem_req);
  assign refill.resp_rdy = (state_q == s_mem_wait);

  always_comb begin
    resp.msg = '0;
    resp.msg[resp_type_lsb]                   = held_wr;
    resp.msg[resp_opaque_lsb +: opaque_nbits] = req_q[req_opaque_lsb +: opaque_nbits];
    resp.msg[resp_data_lsb +: data_nbits]     = resp_data_q;
  end
  assign resp.src = src_q;
  assign resp.val = (state_q == s_resp);

  //====================================================================
  // bank FSM
  //====================================================================

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= s_idle;
      line_valid <= '0;
    end else begin
      case (state_q)
        s_idle: begin
          if (req_fire)
            state_q <= (!in_wr && in_hit) ? s_resp : s_mem_req;
        end
        s_mem_req: begin
          if (refill.req_val && refill.req_rdy) state_q <= s_mem_wait;
        end
        s_mem_wait: begin
          if (refill.resp_val) begin
            state_q <= s_resp;
            if (!held_wr) line_valid[held_idx] <= 1'b1;
          end
        end
        s_resp: begin
          if (resp.rdy) state_q <= s_idle;
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  // request payload, response data and line contents
  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= req.msg;
      src_q <= req.src;
      if (!in_wr && in_hit) resp_data_q <= line_data[in_idx];
      // write hit updates the line, the word still goes to memory
      if (in_wr && in_hit) line_data[in_idx] <= req.msg[req_data_lsb +: data_nbits];
    end
    if (state_q == s_mem_wait && refill.resp_val) begin
      if (held_wr) begin
        resp_data_q <= '0;
      end else begin
        resp_data_q          <= refill.resp_msg[resp_data_lsb +: data_nbits];
        line_data[held_idx]  <= refill.resp_msg[resp_data_lsb +: data_nbits];
        line_tag[held_idx]   <= held_addr[c_tag_lsb +: c_tag_nbits];
      end
    end
  end

endmodule

/* hdl/mcore_ifs.sv */
//======================================================================
// valid/ready channels between the networks and the banks
//======================================================================

`timescale 1ns/1ps

// core request delivered to a bank
interface net_req_if #(parameter int p_num_cores = 4);
  import mcore_pkg::*;

  localparam int c_src_nbits = (p_num_cores > 1) ? $clog2(p_num_cores) : 1;

  req_msg_t                 msg;
  logic [c_src_nbits-1:0]   src;
  logic                     val;
  logic                     rdy;

  modport sender   (output msg, output src, output val, input  rdy);
  modport receiver (input  msg, input  src, input  val, output rdy);
endinterface

// bank response on its way back to a core
interface net_resp_if #(parameter int p_num_cores = 4);
  import mcore_pkg::*;

  localparam int c_src_nbits = (p_num_cores > 1) ? $clog2(p_num_cores) : 1;

  resp_msg_t                msg;
  logic [c_src_nbits-1:0]   src;
  logic                     val;
  logic                     rdy;

  modport sender   (output msg, output src, output val, input  rdy);
  modport receiver (input  msg, input  src, input  val, output rdy);
endinterface

// bank to refill network, request and response pair
interface refill_if;
  import mcore_pkg::*;

  req_msg_t  req_msg;
  logic      req_val;
  logic      req_rdy;
  resp_msg_t resp_msg;
  logic      resp_val;
  logic      resp_rdy;

  modport requester (output req_msg, output req_val, input  req_rdy,
                     input  resp_msg, input  resp_val, output resp_rdy);
  modport memory    (input  req_msg, input  req_val, output req_rdy,
                     output resp_msg, output resp_val, input  resp_rdy);
endinterface

/* hdl/mcore_pkg.sv */
//======================================================================
// shared widths, message types, field offsets, bank state encoding
// and the round-robin pick used by the arbiters
//======================================================================

package mcore_pkg;

  localparam int addr_nbits   = 32;
  localparam int data_nbits   = 32;
  localparam int opaque_nbits = 8;

  typedef logic [addr_nbits-1:0]   addr_t;
  typedef logic [data_nbits-1:0]   data_t;
  typedef logic [opaque_nbits-1:0] opaque_t;

  // request is {type, opaque, addr, data}, response is {type, opaque, data}
  localparam int req_msg_nbits  = 1 + opaque_nbits + addr_nbits + data_nbits;
  localparam int resp_msg_nbits = 1 + opaque_nbits + data_nbits;

  typedef logic [req_msg_nbits-1:0]  req_msg_t;
  typedef logic [resp_msg_nbits-1:0] resp_msg_t;

  localparam int req_data_lsb    = 0;
  localparam int req_addr_lsb    = req_data_lsb + data_nbits;
  localparam int req_opaque_lsb  = req_addr_lsb + addr_nbits;
  localparam int req_type_lsb    = req_opaque_lsb + opaque_nbits;

  localparam int resp_data_lsb   = 0;
  localparam int resp_opaque_lsb = resp_data_lsb + data_nbits;
  localparam int resp_type_lsb   = resp_opaque_lsb + opaque_nbits;

  // word interleaving across banks
  localparam int bank_sel_lsb = 2;

  typedef enum logic [1:0] {s_idle, s_mem_req, s_mem_wait, s_resp} bank_state_t;

  // first requester at or after ptr, ptr itself when none is set
  function automatic int rr_pick(input logic [31:0] req, input int ptr, input int n);
    int pick;
    int idx;
    pick = ptr;
    for (int i = n - 1; i >= 0; i--) begin
      idx = (ptr + i) % n;
      if (req[idx]) pick = idx;
    end
    return pick;
  endfunction

endpackage

/* hdl/mem_net.sv */
//======================================================================
// core to bank crossbar, round-robin per bank for requests and per
// core for responses
//======================================================================

`timescale 1ns/1ps

module mem_net #(
  parameter int p_num_cores = 4
) (
  input  logic                       clk,
  input  logic                       reset,

  input  mcore_pkg::req_msg_t        core_req_msg  [p_num_cores],
  input  logic [p_num_cores-1:0]     core_req_val,
  output logic [p_num_cores-1:0]     core_req_rdy,

  output mcore_pkg::resp_msg_t       core_resp_msg [p_num_cores],
  output logic [p_num_cores-1:0]     core_resp_val,
  input  logic [p_num_cores-1:0]     core_resp_rdy,

  net_req_if.sender                  bank_req  [p_num_cores],
  net_resp_if.receiver               bank_resp [p_num_cores]
);
  import mcore_pkg::*;

  localparam int c_src_nbits = (p_num_cores > 1) ? $clog2(p_num_cores) : 1;

  typedef logic [c_src_nbits-1:0] src_t;

  // bank side copies of the interface signals
  logic [p_num_cores-1:0] breq_rdy;
  logic [p_num_cores-1:0] bresp_val;
  logic [p_num_cores-1:0] bresp_rdy;
  resp_msg_t              bresp_msg [p_num_cores];
  src_t                   bresp_src [p_num_cores];

  src_t                   core_bank [p_num_cores];

  // req_hit[bank][core], resp_hit[core][bank]
  logic [p_num_cores-1:0] req_hit  [p_num_cores];
  logic [p_num_cores-1:0] resp_hit [p_num_cores];
  src_t                   req_sel  [p_num_cores];
  src_t                   resp_sel [p_num_cores];

  always_comb begin
    for (int b = 0; b < p_num_cores; b++) begin
      for (int c = 0; c < p_num_cores; c++) begin
        req_hit[b][c]  = core_req_val[c] && (core_bank[c] == src_t'(b));
        resp_hit[b][c] = bresp_val[c] && (bresp_src[c] == src_t'(b));
      end
    end
  end

  // a grant only completes with the receiver ready
  always_comb begin
    core_req_rdy = '0;
    bresp_rdy    = '0;
    for (int i = 0; i < p_num_cores; i++) begin
      for (int j = 0; j < p_num_cores; j++) begin
        if (req_sel[i] == src_t'(j) && req_hit[i][j] && breq_rdy[i])
          core_req_rdy[j] = 1'b1;
        if (resp_sel[i] == src_t'(j) && resp_hit[i][j] && core_resp_rdy[i])
          bresp_rdy[j] = 1'b1;
      end
    end
  end

  for (genvar g = 0; g < p_num_cores; g++) begin : g_port
    // arbiter state, request side for bank g and response side for core g
    src_t req_ptr_q;
    src_t req_grant_q;
    logic req_hold_q;
    src_t resp_ptr_q;
    src_t resp_grant_q;
    logic resp_hold_q;

    assign core_bank[g] = core_req_msg[g][req_addr_lsb + bank_sel_lsb +: c_src_nbits];

    // a stalled grant is kept so the message stays put
    assign req_sel[g]  = req_hold_q ? req_grant_q :
                         src_t'(rr_pick(32'(req_hit[g]), int'(req_ptr_q), p_num_cores));
    assign resp_sel[g] = resp_hold_q ? resp_grant_q :
                         src_t'(rr_pick(32'(resp_hit[g]), int'(resp_ptr_q), p_num_cores));

    assign bank_req[g].msg = core_req_msg[req_sel[g]];
    assign bank_req[g].src = req_sel[g];
    assign bank_req[g].val = |req_hit[g];
    assign breq_rdy[g]     = bank_req[g].rdy;

    assign bresp_msg[g]     = bank_resp[g].msg;
    assign bresp_src[g]     = bank_resp[g].src;
    assign bresp_val[g]     = bank_resp[g].val;
    assign bank_resp[g].rdy = bresp_rdy[g];

    assign core_resp_msg[g] = bresp_msg[resp_sel[g]];
    assign core_resp_val[g] = |resp_hit[g];

    always_ff @(posedge clk) begin
      if (reset) begin
        req_ptr_q   <= '0;
        req_hold_q  <= 1'b0;
        resp_ptr_q  <= '0;
        resp_hold_q <= 1'b0;
      end else begin
        req_hold_q  <= bank_req[g].val && !breq_rdy[g];
        resp_hold_q <= core_resp_val[g] && !core_resp_rdy[g];
        if (bank_req[g].val && breq_rdy[g])
          req_ptr_q <= (req_sel[g] == src_t'(p_num_cores - 1)) ? '0 : req_sel[g] + 1'b1;
        if (core_resp_val[g] && core_resp_rdy[g])
          resp_ptr_q <= (resp_sel[g] == src_t'(p_num_cores - 1)) ? '0 : resp_sel[g] + 1'b1;
      end
    end

    always_ff @(posedge clk) begin
      req_grant_q  <= req_sel[g];
      resp_grant_q <= resp_sel[g];
    end
  end

endmodule

/* hdl/refill_net.sv */
//======================================================================
// bank misses and writes merged onto the single memory port
//======================================================================

`timescale 1ns/1ps

module refill_net #(
  parameter int p_num_cores = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  refill_if.memory              bank [p_num_cores],

  output mcore_pkg::req_msg_t   mem_req_msg,
  output logic                  mem_req_val,
  input  logic                  mem_req_rdy,

  input  mcore_pkg::resp_msg_t  mem_resp_msg,
  input  logic                  mem_resp_val,
  output logic                  mem_resp_rdy
);
  import mcore_pkg::*;

  localparam int c_src_nbits = (p_num_cores > 1) ? $clog2(p_num_cores) : 1;

  typedef logic [c_src_nbits-1:0] src_t;

  logic [p_num_cores-1:0] breq_val;
  logic [p_num_cores-1:0] bresp_rdy;
  req_msg_t               breq_msg [p_num_cores];

  src_t sel;
  src_t dst;
  src_t ptr_q;
  src_t grant_q;
  logic hold_q;

  // the opaque of a memory response names the bank that asked
  assign dst = mem_resp_msg[resp_opaque_lsb +: c_src_nbits];

  for (genvar g = 0; g < p_num_cores; g++) begin : g_bank
    assign breq_val[g]      = bank[g].req_val;
    assign breq_msg[g]      = bank[g].req_msg;
    assign bank[g].req_rdy  = mem_req_rdy && (sel == src_t'(g));
    assign bank[g].resp_msg = mem_resp_msg;
    assign bank[g].resp_val = mem_resp_val && (dst == src_t'(g));
    assign bresp_rdy[g]     = bank[g].resp_rdy;
  end

  assign sel = hold_q ? grant_q : src_t'(rr_pick(32'(breq_val), int'(ptr_q), p_num_cores));

  always_comb begin
    mem_req_msg = breq_msg[sel];
    mem_req_msg[req_opaque_lsb +: opaque_nbits] = opaque_t'(sel);
  end
  assign mem_req_val  = |breq_val;
  assign mem_resp_rdy = bresp_rdy[dst];

  always_ff @(posedge clk) begin
    if (reset) begin
      ptr_q  <= '0;
      hold_q <= 1'b0;
    end else begin
      hold_q <= mem_req_val && !mem_req_rdy;
      if (mem_req_val && mem_req_rdy)
        ptr_q <= (sel == src_t'(p_num_cores - 1)) ? '0 : sel + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    grant_q <= sel;
  end

endmodule

/* src.f */
hdl/mcore_pkg.sv
hdl/mcore_ifs.sv
hdl/mem_net.sv
hdl/l2_bank.sv
hdl/refill_net.sv
hdl/cache_net_top.sv
testbench/cache_net_props.sv
testbench/cache_net_tb.sv

/* testbench/cache_net_props.sv */
//======================================================================
// bound assertions on the top level: val low after reset, messages
// held while stalled
//======================================================================

`timescale 1ns/1ps

module cache_net_props #(
  parameter int p_num_cores = 4
) (
  input logic                   clk,
  input logic                   reset,
  input mcore_pkg::resp_msg_t   core_resp_msg [p_num_cores],
  input logic [p_num_cores-1:0] core_resp_val,
  input logic [p_num_cores-1:0] core_resp_rdy,
  input mcore_pkg::req_msg_t    mem_req_msg,
  input logic                   mem_req_val,
  input logic                   mem_req_rdy
);

  // one reset edge clears every val output
  a_reset_quiet: assert property (@(posedge clk) reset |=> (core_resp_val == '0) && !mem_req_val)
    else $error("val output high after a reset edge");

  a_mem_req_hold: assert property (@(posedge clk) disable iff (reset)
    mem_req_val && !mem_req_rdy |=> mem_req_val && $stable(mem_req_msg))
    else $error("mem_req_msg changed or dropped while stalled");

  for (genvar g = 0; g < p_num_cores; g++) begin : g_core
    a_resp_hold: assert property (@(posedge clk) disable iff (reset)
      core_resp_val[g] && !core_resp_rdy[g] |=> core_resp_val[g] && $stable(core_resp_msg[g]))
      else $error("core_resp_msg[%0d] changed or dropped while stalled", g);
  end

endmodule

bind cache_net_top cache_net_props #(.p_num_cores(p_num_cores)) cache_net_props_inst (
  .clk           (clk),
  .reset         (reset),
  .core_resp_msg (core_resp_msg),
  .core_resp_val (core_resp_val),
  .core_resp_rdy (core_resp_rdy),
  .mem_req_msg   (mem_req_msg),
  .mem_req_val   (mem_req_val),
  .mem_req_rdy   (mem_req_rdy)
);

/* testbench/cache_net_tb.sv */
//======================================================================
// testbench for the shared level-two data path: clock, reset, memory
// model, stimulus table, response checks and watchdog
//======================================================================

`timescale 1ns/1ps

module cache_net_tb;
  import mcore_pkg::*;

  localparam int n_cores        = 4;
  localparam int reset_cycles   = 16;
  localparam int cycles_per_row = 200;

  typedef struct packed {
    int    test;
    int    core;
    logic  par;
    logic  wr;
    addr_t addr;
    data_t data;
    data_t exp;
  } row_t;

  logic               clk;
  logic               reset;
  req_msg_t           core_req_msg  [n_cores];
  logic [n_cores-1:0] core_req_val;
  logic [n_cores-1:0] core_req_rdy;
  resp_msg_t          core_resp_msg [n_cores];
  logic [n_cores-1:0] core_resp_val;
  logic [n_cores-1:0] core_resp_rdy;
  req_msg_t           mem_req_msg;
  logic               mem_req_val;
  logic               mem_req_rdy;
  resp_msg_t          mem_resp_msg;
  logic               mem_resp_val;
  logic               mem_resp_rdy;

  row_t               rows [$];
  resp_msg_t          mem_q [$];
  data_t              mem_words [addr_t];
  logic [15:0]        lfsr_q;
  logic               stall_on;
  logic               table_ready;
  logic [n_cores-1:0] req_pend;
  logic [n_cores-1:0] resp_wait;
  req_msg_t           req_out  [n_cores];
  int                 resp_row [n_cores];
  int                 n_checks;
  int                 n_errors;

  cache_net_top #(.p_num_cores(n_cores), .p_num_lines(16)) cache_net_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //====================================================================
  // stimulus table
  //====================================================================

  function automatic void add_write(input int test, input int core, input logic par,
                                    input addr_t addr, input data_t data);
    rows.push_back('{test, core, par, 1'b1, addr, data, 32'h0});
  endfunction

  function automatic void add_read(input int test, input int core, input logic par,
                                   input addr_t addr, input data_t exp);
    rows.push_back('{test, core, par, 1'b0, addr, 32'h0, exp});
  endfunction

  // par set means the row goes out together with the one before it
  function automatic void build_table();
    add_write(1, 0, 0, 32'h0000_0100, 32'ha5a5_0001);
    add_read (1, 0, 0, 32'h0000_0100, 32'ha5a5_0001);
    add_write(1, 2, 0, 32'h0000_0208, 32'h5a5a_0002);
    add_read (1, 2, 0, 32'h0000_0208, 32'h5a5a_0002);
    // one writer, the others read, then a write hit
    add_write(2, 1, 0, 32'h0000_030c, 32'hc0de_0003);
    add_read (2, 0, 0, 32'h0000_030c, 32'hc0de_0003);
    add_read (2, 2, 0, 32'h0000_030c, 32'hc0de_0003);
    add_read (2, 3, 0, 32'h0000_030c, 32'hc0de_0003);
    add_write(2, 3, 0, 32'h0000_030c, 32'hbeef_0004);
    add_read (2, 1, 0, 32'h0000_030c, 32'hbeef_0004);
    // never written so the address comes back
    add_read (3, 3, 0, 32'h0000_5440, 32'h0000_5440);
    add_read (3, 3, 0, 32'h0000_5440, 32'h0000_5440);
    add_read (3, 1, 0, 32'h00ab_c0f4, 32'h00ab_c0f4);
    add_read (3, 0, 0, 32'h00ab_c0f4, 32'h00ab_c0f4);
    // 0x1010 and 0x2010 share bank 0 line 1
    add_write(4, 0, 0, 32'h0000_1010, 32'h1111_aaaa);
    add_write(4, 1, 0, 32'h0000_2010, 32'h2222_bbbb);
    add_read (4, 2, 0, 32'h0000_1010, 32'h1111_aaaa);
    add_read (4, 3, 0, 32'h0000_2010, 32'h2222_bbbb);
    add_write(4, 0, 0, 32'h0000_1010, 32'h3333_cccc);
    add_read (4, 1, 0, 32'h0000_2010, 32'h2222_bbbb);
    add_read (4, 2, 0, 32'h0000_1010, 32'h3333_cccc);
    // four cores at once, one bank each
    add_read (5, 0, 0, 32'h0000_0100, 32'ha5a5_0001);
    add_write(5, 1, 1, 32'h0000_0604, 32'h6666_0005);
    add_read (5, 2, 1, 32'h0000_0208, 32'h5a5a_0002);
    add_read (5, 3, 1, 32'h0000_030c, 32'hbeef_0004);
    add_read (5, 0, 0, 32'h0000_0604, 32'h6666_0005);
    add_read (5, 1, 1, 32'h0000_0208, 32'h5a5a_0002);
    add_read (5, 2, 1, 32'h0000_030c, 32'hbeef_0004);
    add_read (5, 3, 1, 32'h0000_0100, 32'ha5a5_0001);
  endfunction

  function automatic string test_label(input int test);
    case (test)
      1:       return "read after write";
      2:       return "sharing across cores";
      3:       return "miss data";
      4:       return "conflicting addresses";
      default: return "concurrency";
    endcase
  endfunction

  //====================================================================
  // random stalls and memory model
  //====================================================================

  // fibonacci LFSR, taps 16 14 13 11
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  // rdy low on about one cycle in four
  function automatic logic stall_rdy();
    logic a;
    logic b;
    if (!stall_on) return 1'b1;
    a = lfsr_bit();
    b = lfsr_bit();
    return !(a && b);
  endfunction

  // answer built when the request is taken, replayed in order
  function automatic resp_msg_t mem_answer(input req_msg_t req);
    logic    wr;
    opaque_t op;
    addr_t   addr;
    data_t   data;
    data_t   rd;
    {wr, op, addr, data} = req;
    rd = '0;
    if (wr) mem_words[addr] = data;
    else rd = mem_words.exists(addr) ? mem_words[addr] : addr;
    return {wr, op, rd};
  endfunction

  //====================================================================
  // checks
  //====================================================================

  // type and opaque fields, data is checked on its own
  task automatic check_resp(input string name, input resp_msg_t got, input resp_msg_t exp);
    resp_msg_t mask;
    mask = {1'b1, {8{1'b1}}, {32{1'b0}}};
    n_checks++;
    if ((got & mask) !== (exp & mask)) begin
      n_errors++;
      $display("Mismatch %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_data(input string name, input data_t got, input data_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic take_resp(input int c);
    row_t      row;
    resp_msg_t exp;
    if (!resp_wait[c]) begin
      n_errors++;
      $display("core %0d got a response with no request outstanding", c);
    end else begin
      row          = rows[resp_row[c]];
      exp          = {row.wr, opaque_t'(resp_row[c]), row.exp};
      resp_wait[c] = 1'b0;
      check_resp($sformatf("core_resp_msg[%0d]", c), core_resp_msg[c], exp);
      if (!row.wr)
        check_data($sformatf("core_resp_msg[%0d] data", c), core_resp_msg[c][31:0], row.exp);
    end
  endtask

  task automatic issue_row(input int r);
    int c;
    c            = rows[r].core;
    req_out[c]   = {rows[r].wr, opaque_t'(r), rows[r].addr, rows[r].data};
    req_pend[c]  = 1'b1;
    resp_wait[c] = 1'b1;
    resp_row[c]  = r;
  endtask

  // drive on the falling edge, then note which transfers the next rising edge takes
  task automatic run_cycle();
    @(negedge clk);
    for (int c = 0; c < n_cores; c++) begin
      core_req_val[c]  = req_pend[c];
      core_req_msg[c]  = req_out[c];
      core_resp_rdy[c] = stall_rdy();
    end
    mem_req_rdy  = stall_rdy();
    mem_resp_val = (mem_q.size() != 0);
    mem_resp_msg = (mem_q.size() != 0) ? mem_q[0] : '0;
    #1;
    for (int c = 0; c < n_cores; c++) begin
      if (core_req_val[c] && core_req_rdy[c]) req_pend[c] = 1'b0;
      if (core_resp_val[c] && core_resp_rdy[c]) take_resp(c);
    end
    if (mem_req_val && mem_req_rdy) mem_q.push_back(mem_answer(mem_req_msg));
    if (mem_resp_val && mem_resp_rdy) void'(mem_q.pop_front());
  endtask

  //====================================================================
  // main sequence and watchdog
  //====================================================================

  initial begin
    int r;
    int first;
    int checks_at;
    int errors_at;
    reset         = 1'b1;
    core_req_val  = '0;
    core_resp_rdy = '1;
    mem_req_rdy   = 1'b1;
    mem_resp_val  = 1'b0;
    mem_resp_msg  = '0;
    for (int c = 0; c < n_cores; c++) begin
      core_req_msg[c] = '0;
      req_out[c]      = '0;
      resp_row[c]     = 0;
    end
    lfsr_q      = 16'd17;
    stall_on    = 1'b0;
    req_pend    = '0;
    resp_wait   = '0;
    n_checks    = 0;
    n_errors    = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // second pass is the same table under random rdy stalls
    for (int pass = 0; pass < 2; pass++) begin
      stall_on = (pass == 1);
      r = 0;
      while (r < rows.size()) begin
        first     = r;
        checks_at = n_checks;
        errors_at = n_errors;
        while (r < rows.size() && rows[r].test == rows[first].test) begin
          issue_row(r);
          r++;
          while (r < rows.size() && rows[r].par) begin
            issue_row(r);
            r++;
          end
          while ((req_pend | resp_wait) != '0) run_cycle();
        end
        $display("test %0d %s, %s: %0d checks, %0d errors", rows[first].test,
                 test_label(rows[first].test), stall_on ? "with stalls" : "no stalls",
                 n_checks - checks_at, n_errors - errors_at);
      end
    end
    // quiet cycles catch duplicated responses
    stall_on = 1'b0;
    repeat (20) run_cycle();
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  initial begin
    wait (table_ready === 1'b1);
    repeat (reset_cycles + 2 * cycles_per_row * rows.size() + 20) @(posedge clk);
    $display("timeout, responses still outstanding when the cycle budget ran out");
    $display("CHECKS FAILED");
    $finish;
  end

endmodule
